// File: hw/cnn_pkg.sv
package cnn_pkg;

  localparam int ADDR_W     = 8;
  localparam int DATA_W     = 16;
  localparam int PIX_W      = 8;
  localparam int SHIFT_W    = 3;
  localparam int MAC_W      = 18;
  localparam int MAX_PIXELS = 64;

  // Param memory map
  localparam logic [ADDR_W-1:0] PARAM_COUNT_ADDR  = 8'd0;
  localparam logic [ADDR_W-1:0] PARAM_WEIGHT_ADDR = 8'd1;
  localparam logic [ADDR_W-1:0] PARAM_BIAS_ADDR   = 8'd2;
  localparam logic [ADDR_W-1:0] PARAM_SHIFT_ADDR  = 8'd3;

  // Signed 8-bit output range
  localparam logic signed [PIX_W-1:0] PIX_MAX = 8'sh7f;
  localparam logic signed [PIX_W-1:0] PIX_MIN = 8'sh80;

  typedef enum logic [3:0] {
    MODE_IDLE     = 4'd0,
    MODE_CONV_1X1 = 4'd1,
    MODE_MAX_POOL = 4'd2
  } layer_mode_e;

  typedef enum logic [1:0] {
    CONV_IDLE  = 2'd0,
    CONV_CFG   = 2'd1,
    CONV_RUN   = 2'd2,
    CONV_DRAIN = 2'd3
  } conv_state_e;

  typedef enum logic [1:0] {
    POOL_IDLE  = 2'd0,
    POOL_CFG   = 2'd1,
    POOL_RUN   = 2'd2,
    POOL_DRAIN = 2'd3
  } pool_state_e;

  // Master to memory
  typedef struct packed {
    logic              cs;
    logic              oe;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } sram_req_t;

  // Memory to master
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } sram_rsp_t;

endpackage

// File: hw/conv_1x1_unit.sv
`timescale 1ns/10ps

module conv_1x1_unit (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               start_i,
  output logic               busy_o,
  output logic               done_o,
  output cnn_pkg::sram_req_t param_req_o,
  input  cnn_pkg::sram_rsp_t param_rsp_i,
  output cnn_pkg::sram_req_t input_req_o,
  input  cnn_pkg::sram_rsp_t input_rsp_i,
  output cnn_pkg::sram_req_t output_req_o
);

  cnn_pkg::conv_state_e              state_q;
  logic [cnn_pkg::ADDR_W-1:0]        cfg_addr_q;
  logic                              prm_vld_q;
  logic [cnn_pkg::ADDR_W-1:0]        prm_addr_q;
  logic [cnn_pkg::ADDR_W-1:0]        count_q;
  logic signed [cnn_pkg::PIX_W-1:0]  weight_q;
  logic signed [cnn_pkg::DATA_W-1:0] bias_q;
  logic [cnn_pkg::SHIFT_W-1:0]       shift_q;
  logic [cnn_pkg::ADDR_W-1:0]        rd_addr_q;
  logic [cnn_pkg::ADDR_W-1:0]        out_idx_q;
  logic [2:0]                        vld_q;
  logic signed [cnn_pkg::MAC_W-1:0]  mac_q;
  logic signed [cnn_pkg::PIX_W-1:0]  res_q;
  logic                              wr_q;
  logic [cnn_pkg::ADDR_W-1:0]        wr_addr_q;
  logic [cnn_pkg::DATA_W-1:0]        wr_data_q;
  logic                              done_q;
  logic                              rd_go;
  logic                              last_wr;
  logic signed [cnn_pkg::PIX_W-1:0]  pix;
  logic signed [cnn_pkg::MAC_W-1:0]  shifted;

  assign rd_go   = (state_q == cnn_pkg::CONV_RUN);
  assign pix     = input_rsp_i.rdata[cnn_pkg::PIX_W-1:0];
  assign shifted = mac_q >>> shift_q;
  // Final result leaves the saturation stage
  assign last_wr = vld_q[2] && (out_idx_q == count_q - 1'b1);

  always_comb begin
    param_req_o       = '0;
    param_req_o.cs    = (state_q == cnn_pkg::CONV_CFG);
    param_req_o.oe    = (state_q == cnn_pkg::CONV_CFG);
    param_req_o.addr  = cfg_addr_q;
    input_req_o       = '0;
    input_req_o.cs    = rd_go;
    input_req_o.oe    = rd_go;
    input_req_o.addr  = rd_addr_q;
    output_req_o       = '0;
    output_req_o.cs    = wr_q;
    output_req_o.we    = wr_q;
    output_req_o.addr  = wr_addr_q;
    output_req_o.wdata = wr_data_q;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= cnn_pkg::CONV_IDLE;
      cfg_addr_q <= '0;
      prm_vld_q  <= 1'b0;
      prm_addr_q <= '0;
      rd_addr_q  <= '0;
      out_idx_q  <= '0;
      vld_q      <= '0;
      wr_q       <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      prm_vld_q  <= (state_q == cnn_pkg::CONV_CFG);
      prm_addr_q <= cfg_addr_q;
      vld_q      <= {vld_q[1:0], rd_go};
      wr_q       <= vld_q[2];
      done_q     <= last_wr;
      if (vld_q[2]) begin
        out_idx_q <= out_idx_q + 1'b1;
      end
      case (state_q)
        cnn_pkg::CONV_IDLE: begin
          if (start_i) begin
            cfg_addr_q <= cnn_pkg::PARAM_COUNT_ADDR;
            rd_addr_q  <= '0;
            out_idx_q  <= '0;
            state_q    <= cnn_pkg::CONV_CFG;
          end
        end
        cnn_pkg::CONV_CFG: begin
          cfg_addr_q <= cfg_addr_q + 1'b1;
          if (cfg_addr_q == cnn_pkg::PARAM_SHIFT_ADDR) state_q <= cnn_pkg::CONV_RUN;
        end
        cnn_pkg::CONV_RUN: begin
          rd_addr_q <= rd_addr_q + 1'b1;
          if (rd_addr_q == count_q - 1'b1) state_q <= cnn_pkg::CONV_DRAIN;
        end
        default: begin
          if (last_wr) state_q <= cnn_pkg::CONV_IDLE;
        end
      endcase
    end
  end

  // Scalars land one cycle after each param read
  always_ff @(posedge clk) begin
    if (prm_vld_q) begin
      case (prm_addr_q)
        cnn_pkg::PARAM_COUNT_ADDR:  count_q  <= param_rsp_i.rdata[cnn_pkg::ADDR_W-1:0];
        cnn_pkg::PARAM_WEIGHT_ADDR: weight_q <= param_rsp_i.rdata[cnn_pkg::PIX_W-1:0];
        cnn_pkg::PARAM_BIAS_ADDR:   bias_q   <= param_rsp_i.rdata;
        default:                    shift_q  <= param_rsp_i.rdata[cnn_pkg::SHIFT_W-1:0];
      endcase
    end
  end

  // MAC, then shift and clamp, then write
  always_ff @(posedge clk) begin
    mac_q <= pix * weight_q + bias_q;
    if (shifted > cnn_pkg::PIX_MAX) begin
      res_q <= cnn_pkg::PIX_MAX;
    end else if (shifted < cnn_pkg::PIX_MIN) begin
      res_q <= cnn_pkg::PIX_MIN;
    end else begin
      res_q <= shifted[cnn_pkg::PIX_W-1:0];
    end
    if (vld_q[2]) begin
      wr_addr_q <= out_idx_q;
      wr_data_q <= {{(cnn_pkg::DATA_W-cnn_pkg::PIX_W){res_q[cnn_pkg::PIX_W-1]}}, res_q};
    end
  end

  assign busy_o = (state_q != cnn_pkg::CONV_IDLE);
  assign done_o = done_q;

  // Reads and writes stay below the pixel count
  a_access_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(input_req_o.cs && (input_req_o.addr >= count_q)) &&
    !(output_req_o.cs && (output_req_o.addr >= count_q)));

endmodule

// File: hw/maxpool_unit.sv
`timescale 1ns/10ps

module maxpool_unit (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               start_i,
  output logic               busy_o,
  output logic               done_o,
  output cnn_pkg::sram_req_t param_req_o,
  input  cnn_pkg::sram_rsp_t param_rsp_i,
  output cnn_pkg::sram_req_t input_req_o,
  input  cnn_pkg::sram_rsp_t input_rsp_i,
  output cnn_pkg::sram_req_t output_req_o
);

  cnn_pkg::pool_state_e             state_q;
  logic                             prm_vld_q;
  logic [cnn_pkg::ADDR_W-1:0]       count_q;
  logic [cnn_pkg::ADDR_W-1:0]       rd_addr_q;
  logic [cnn_pkg::ADDR_W-1:0]       out_idx_q;
  logic                             rd_vld_q;
  logic                             rd_odd_q;
  logic signed [cnn_pkg::PIX_W-1:0] first_q;
  logic                             wr_q;
  logic [cnn_pkg::ADDR_W-1:0]       wr_addr_q;
  logic [cnn_pkg::DATA_W-1:0]       wr_data_q;
  logic                             done_q;
  logic                             pair_done;
  logic                             last_wr;
  logic signed [cnn_pkg::PIX_W-1:0] pix;
  logic signed [cnn_pkg::PIX_W-1:0] larger;

  assign pix       = input_rsp_i.rdata[cnn_pkg::PIX_W-1:0];
  assign larger    = (pix > first_q) ? pix : first_q;
  // Second value of a pair is on rdata
  assign pair_done = rd_vld_q && rd_odd_q;
  assign last_wr   = pair_done && (out_idx_q == (count_q >> 1) - 1'b1);

  always_comb begin
    param_req_o        = '0;
    param_req_o.cs     = (state_q == cnn_pkg::POOL_CFG);
    param_req_o.oe     = (state_q == cnn_pkg::POOL_CFG);
    param_req_o.addr   = cnn_pkg::PARAM_COUNT_ADDR;
    input_req_o        = '0;
    input_req_o.cs     = (state_q == cnn_pkg::POOL_RUN);
    input_req_o.oe     = (state_q == cnn_pkg::POOL_RUN);
    input_req_o.addr   = rd_addr_q;
    output_req_o       = '0;
    output_req_o.cs    = wr_q;
    output_req_o.we    = wr_q;
    output_req_o.addr  = wr_addr_q;
    output_req_o.wdata = wr_data_q;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= cnn_pkg::POOL_IDLE;
      prm_vld_q <= 1'b0;
      count_q   <= '0;
      rd_addr_q <= '0;
      out_idx_q <= '0;
      rd_vld_q  <= 1'b0;
      rd_odd_q  <= 1'b0;
      wr_q      <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      prm_vld_q <= (state_q == cnn_pkg::POOL_CFG);
      rd_vld_q  <= (state_q == cnn_pkg::POOL_RUN);
      rd_odd_q  <= rd_addr_q[0];
      wr_q      <= pair_done;
      done_q    <= last_wr;
      if (prm_vld_q) count_q <= param_rsp_i.rdata[cnn_pkg::ADDR_W-1:0];
      if (pair_done) out_idx_q <= out_idx_q + 1'b1;
      case (state_q)
        cnn_pkg::POOL_IDLE: begin
          if (start_i) begin
            rd_addr_q <= '0;
            out_idx_q <= '0;
            state_q   <= cnn_pkg::POOL_CFG;
          end
        end
        cnn_pkg::POOL_CFG: state_q <= cnn_pkg::POOL_RUN;
        cnn_pkg::POOL_RUN: begin
          rd_addr_q <= rd_addr_q + 1'b1;
          if (rd_addr_q == count_q - 1'b1) state_q <= cnn_pkg::POOL_DRAIN;
        end
        default: begin
          if (last_wr) state_q <= cnn_pkg::POOL_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_vld_q && !rd_odd_q) first_q <= pix;
    if (pair_done) begin
      wr_addr_q <= out_idx_q;
      wr_data_q <= {{(cnn_pkg::DATA_W-cnn_pkg::PIX_W){larger[cnn_pkg::PIX_W-1]}}, larger};
    end
  end

  assign busy_o = (state_q != cnn_pkg::POOL_IDLE);
  assign done_o = done_q;

  // Count from param memory must pair up and fit
  a_count_even: assert property (@(posedge clk) disable iff (!rst_n_i)
    prm_vld_q |-> (!param_rsp_i.rdata[0] && (param_rsp_i.rdata != '0) &&
                   (param_rsp_i.rdata <= cnn_pkg::MAX_PIXELS)));

endmodule

// File: hw/bus_switcher.sv
`timescale 1ns/10ps

module bus_switcher (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 start_i,
  input  cnn_pkg::layer_mode_e mode_i,
  output logic                 busy_o,
  output logic                 done_o,
  // 1x1 conv unit
  output logic                 conv_start_o,
  input  logic                 conv_busy_i,
  input  logic                 conv_done_i,
  input  cnn_pkg::sram_req_t   conv_param_req_i,
  output cnn_pkg::sram_rsp_t   conv_param_rsp_o,
  input  cnn_pkg::sram_req_t   conv_input_req_i,
  output cnn_pkg::sram_rsp_t   conv_input_rsp_o,
  input  cnn_pkg::sram_req_t   conv_output_req_i,
  // Max pooling unit
  output logic                 pool_start_o,
  input  logic                 pool_busy_i,
  input  logic                 pool_done_i,
  input  cnn_pkg::sram_req_t   pool_param_req_i,
  output cnn_pkg::sram_rsp_t   pool_param_rsp_o,
  input  cnn_pkg::sram_req_t   pool_input_req_i,
  output cnn_pkg::sram_rsp_t   pool_input_rsp_o,
  input  cnn_pkg::sram_req_t   pool_output_req_i,
  // Shared memories
  output cnn_pkg::sram_req_t   param_req_o,
  input  cnn_pkg::sram_rsp_t   param_rsp_i,
  output cnn_pkg::sram_req_t   input_req_o,
  input  cnn_pkg::sram_rsp_t   input_rsp_i,
  output cnn_pkg::sram_req_t   output_req_o
);

  cnn_pkg::layer_mode_e mode_q;
  logic                 conv_sel;
  logic                 pool_sel;
  logic                 mode_ok;
  logic                 accept;

  assign conv_sel = (mode_q == cnn_pkg::MODE_CONV_1X1);
  assign pool_sel = (mode_q == cnn_pkg::MODE_MAX_POOL);
  assign mode_ok  = (mode_i == cnn_pkg::MODE_CONV_1X1) || (mode_i == cnn_pkg::MODE_MAX_POOL);
  // Only taken while no layer owns the memories
  assign accept   = start_i && mode_ok && (mode_q == cnn_pkg::MODE_IDLE);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mode_q       <= cnn_pkg::MODE_IDLE;
      conv_start_o <= 1'b0;
      pool_start_o <= 1'b0;
    end else begin
      conv_start_o <= accept && (mode_i == cnn_pkg::MODE_CONV_1X1);
      pool_start_o <= accept && (mode_i == cnn_pkg::MODE_MAX_POOL);
      if (accept) begin
        mode_q <= mode_i;
      end else if (done_o) begin
        mode_q <= cnn_pkg::MODE_IDLE;
      end
    end
  end

  assign busy_o = (conv_sel && conv_busy_i) || (pool_sel && pool_busy_i);
  assign done_o = (conv_sel && conv_done_i) || (pool_sel && pool_done_i);

  always_comb begin
    param_req_o      = '0;
    input_req_o      = '0;
    output_req_o     = '0;
    conv_param_rsp_o = '0;
    conv_input_rsp_o = '0;
    pool_param_rsp_o = '0;
    pool_input_rsp_o = '0;
    if (conv_sel) begin
      param_req_o      = conv_param_req_i;
      input_req_o      = conv_input_req_i;
      output_req_o     = conv_output_req_i;
      conv_param_rsp_o = param_rsp_i;
      conv_input_rsp_o = input_rsp_i;
    end else if (pool_sel) begin
      param_req_o      = pool_param_req_i;
      input_req_o      = pool_input_req_i;
      output_req_o     = pool_output_req_i;
      pool_param_rsp_o = param_rsp_i;
      pool_input_rsp_o = input_rsp_i;
    end
  end

  a_conv_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
    !conv_sel |-> !(conv_param_req_i.cs || conv_input_req_i.cs || conv_output_req_i.cs));

  a_pool_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
    !pool_sel |-> !(pool_param_req_i.cs || pool_input_req_i.cs || pool_output_req_i.cs));

endmodule

// File: hw/cnn_layer_top.sv
`timescale 1ns/10ps

module cnn_layer_top (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 start_i,
  input  cnn_pkg::layer_mode_e mode_i,
  output logic                 busy_o,
  output logic                 done_o,
  output cnn_pkg::sram_req_t   param_req_o,
  input  cnn_pkg::sram_rsp_t   param_rsp_i,
  output cnn_pkg::sram_req_t   input_req_o,
  input  cnn_pkg::sram_rsp_t   input_rsp_i,
  output cnn_pkg::sram_req_t   output_req_o
);

  logic               conv_start;
  logic               conv_busy;
  logic               conv_done;
  cnn_pkg::sram_req_t conv_param_req;
  cnn_pkg::sram_rsp_t conv_param_rsp;
  cnn_pkg::sram_req_t conv_input_req;
  cnn_pkg::sram_rsp_t conv_input_rsp;
  cnn_pkg::sram_req_t conv_output_req;

  logic               pool_start;
  logic               pool_busy;
  logic               pool_done;
  cnn_pkg::sram_req_t pool_param_req;
  cnn_pkg::sram_rsp_t pool_param_rsp;
  cnn_pkg::sram_req_t pool_input_req;
  cnn_pkg::sram_rsp_t pool_input_rsp;
  cnn_pkg::sram_req_t pool_output_req;

  conv_1x1_unit conv_1x1_unit_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .start_i      (conv_start),
    .busy_o       (conv_busy),
    .done_o       (conv_done),
    .param_req_o  (conv_param_req),
    .param_rsp_i  (conv_param_rsp),
    .input_req_o  (conv_input_req),
    .input_rsp_i  (conv_input_rsp),
    .output_req_o (conv_output_req)
  );

  maxpool_unit maxpool_unit_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .start_i      (pool_start),
    .busy_o       (pool_busy),
    .done_o       (pool_done),
    .param_req_o  (pool_param_req),
    .param_rsp_i  (pool_param_rsp),
    .input_req_o  (pool_input_req),
    .input_rsp_i  (pool_input_rsp),
    .output_req_o (pool_output_req)
  );

  // Mode latch and memory steering
  bus_switcher bus_switcher_inst (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .start_i           (start_i),
    .mode_i            (mode_i),
    .busy_o            (busy_o),
    .done_o            (done_o),
    .conv_start_o      (conv_start),
    .conv_busy_i       (conv_busy),
    .conv_done_i       (conv_done),
    .conv_param_req_i  (conv_param_req),
    .conv_param_rsp_o  (conv_param_rsp),
    .conv_input_req_i  (conv_input_req),
    .conv_input_rsp_o  (conv_input_rsp),
    .conv_output_req_i (conv_output_req),
    .pool_start_o      (pool_start),
    .pool_busy_i       (pool_busy),
    .pool_done_i       (pool_done),
    .pool_param_req_i  (pool_param_req),
    .pool_param_rsp_o  (pool_param_rsp),
    .pool_input_req_i  (pool_input_req),
    .pool_input_rsp_o  (pool_input_rsp),
    .pool_output_req_i (pool_output_req),
    .param_req_o       (param_req_o),
    .param_rsp_i       (param_rsp_i),
    .input_req_o       (input_req_o),
    .input_rsp_i       (input_rsp_i),
    .output_req_o      (output_req_o)
  );

endmodule

// File: verif/sram_model.sv
`timescale 1ns/10ps

module sram_model (
  input  logic               clk,
  input  cnn_pkg::sram_req_t req_i,
  output cnn_pkg::sram_rsp_t rsp_o
);

  logic [cnn_pkg::DATA_W-1:0] mem [0:255];

  initial rsp_o = '0;

  // Background pattern, distinct for every address
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {~i[7:0], i[7:0]};
    end
  end

  // Read data one cycle after the strobe
  always @(posedge clk) begin
    if (req_i.cs && req_i.we) begin
      mem[req_i.addr] <= req_i.wdata;
    end
    if (req_i.cs && req_i.oe) begin
      rsp_o.rdata <= mem[req_i.addr];
    end
  end

  task preload(input logic [cnn_pkg::ADDR_W-1:0] addr,
               input logic [cnn_pkg::DATA_W-1:0] data);
    mem[addr] = data;
  endtask

endmodule

// File: verif/tb_cnn_layer.sv
`timescale 1ns/10ps

module tb_cnn_layer;

  localparam int RUNS = 9;

  logic                 clk;
  logic                 rst_n_i;
  logic                 start_i;
  cnn_pkg::layer_mode_e mode_i;
  logic                 busy_o;
  logic                 done_o;
  cnn_pkg::sram_req_t   param_req_o;
  cnn_pkg::sram_rsp_t   param_rsp_i;
  cnn_pkg::sram_req_t   input_req_o;
  cnn_pkg::sram_rsp_t   input_rsp_i;
  cnn_pkg::sram_req_t   output_req_o;

  // Copy of what the memories hold for the current run
  logic signed [cnn_pkg::PIX_W-1:0]  pix_img [0:cnn_pkg::MAX_PIXELS-1];
  logic signed [cnn_pkg::PIX_W-1:0]  weight_v;
  logic signed [cnn_pkg::DATA_W-1:0] bias_v;
  logic [cnn_pkg::SHIFT_W-1:0]       shift_v;

  cnn_pkg::layer_mode_e run_mode;
  int     run_writes;
  int     wr_count;
  bit     run_active;
  bit     done_seen;
  int     write_errors;
  int     other_errors;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;
  integer seed;
  int     counts [0:RUNS-1];

  initial clk = 1'b0;
  always #2 clk = ~clk;

  cnn_layer_top cnn_layer_top_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .start_i      (start_i),
    .mode_i       (mode_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .param_req_o  (param_req_o),
    .param_rsp_i  (param_rsp_i),
    .input_req_o  (input_req_o),
    .input_rsp_i  (input_rsp_i),
    .output_req_o (output_req_o)
  );

  sram_model param_mem_inst (.clk(clk), .req_i(param_req_o), .rsp_o(param_rsp_i));
  sram_model input_mem_inst (.clk(clk), .req_i(input_req_o), .rsp_o(input_rsp_i));

  function automatic logic [cnn_pkg::DATA_W-1:0] ref_output(
    input cnn_pkg::layer_mode_e mode, input int idx);
    integer acc;
    logic signed [7:0] res;
    logic signed [7:0] a;
    logic signed [7:0] b;
    if (mode == cnn_pkg::MODE_CONV_1X1) begin
      acc = pix_img[idx] * weight_v + bias_v;
      acc = acc >>> shift_v;
      if (acc > 127) res = 8'sh7f;
      else if (acc < -128) res = 8'sh80;
      else res = acc[7:0];
    end else begin
      a = pix_img[2*idx];
      b = pix_img[2*idx+1];
      res = (a > b) ? a : b;
    end
    return {{8{res[7]}}, res};
  endfunction

  task automatic check_write(input cnn_pkg::sram_req_t exp_req,
                             input cnn_pkg::sram_req_t act_req);
    if (act_req !== exp_req) begin
      write_errors++;
      $display(
        "CHECK FAILED output_req_o: exp addr 0x%02h wdata 0x%04h, got addr 0x%02h wdata 0x%04h",
        exp_req.addr, exp_req.wdata, act_req.addr, act_req.wdata);
    end
  endtask

  task automatic check_mode(input cnn_pkg::layer_mode_e mode, input int exp_cnt,
                            input int act_cnt);
    if (act_cnt != exp_cnt) begin
      write_errors++;
      $display("CHECK FAILED write_count %s: expected 0x%0h got 0x%0h",
               mode.name(), exp_cnt, act_cnt);
    end
  endtask

  task automatic idle_bus_check(input string what);
    if (busy_o || done_o ||
        param_req_o.cs || param_req_o.oe || param_req_o.we ||
        input_req_o.cs || input_req_o.oe || input_req_o.we ||
        output_req_o.cs || output_req_o.oe || output_req_o.we) begin
      other_errors++;
      $display("Unexpected busy, done or memory activity %s", what);
    end
  endtask

  // Output bus monitor
  always @(negedge clk) begin : monitor_writes
    cnn_pkg::sram_req_t exp_req;
    if (rst_n_i && output_req_o.cs) begin
      if (!run_active) begin
        other_errors++;
        $display("Output write to address 0x%02h with no run active", output_req_o.addr);
      end else if (wr_count >= run_writes) begin
        other_errors++;
        $display("Extra output write beyond %0d results", run_writes);
      end else begin
        exp_req       = '0;
        exp_req.cs    = 1'b1;
        exp_req.we    = 1'b1;
        exp_req.addr  = wr_count[7:0];
        exp_req.wdata = ref_output(run_mode, wr_count);
        check_write(exp_req, output_req_o);
      end
      wr_count++;
    end
    if (rst_n_i && done_o) begin
      if (!run_active) begin
        other_errors++;
        $display("done_o pulsed with no run active");
      end
      if (busy_o) begin
        other_errors++;
        $display("busy_o still high in the done_o cycle");
      end
      run_active = 1'b0;
      done_seen  = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT did not finish", cycle_cnt);
      $display("Errors: %0d value mismatches, %0d other failures", write_errors,
               other_errors + 1);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic load_memories(input cnn_pkg::layer_mode_e mode, input int count,
                               input bit sat);
    int r;
    logic [7:0] rnd;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      rnd = r[7:0];
      // Both saturation ends, zero and minus one
      if (sat && i < 4) begin
        case (i)
          0: rnd = 8'h7f;
          1: rnd = 8'h80;
          2: rnd = 8'h00;
          default: rnd = 8'hff;
        endcase
      end
      // Equal pairs and negative pairs for pooling
      if (mode == cnn_pkg::MODE_MAX_POOL) begin
        if ((i / 2) % 4 == 1 && i % 2 == 1) rnd = pix_img[i-1];
        if ((i / 2) % 4 == 2) rnd[7] = 1'b1;
      end
      pix_img[i] = rnd;
      input_mem_inst.preload(i[7:0], {{8{rnd[7]}}, rnd});
    end
    if (sat) begin
      weight_v = 8'sd127;
      bias_v   = 16'sd5;
      shift_v  = 3'd1;
    end else begin
      r = $random(seed);
      weight_v = r[7:0];
      r = $random(seed) % 1024;
      bias_v = r[15:0];
      r = $random(seed);
      shift_v = r[2:0];
    end
    param_mem_inst.preload(cnn_pkg::PARAM_COUNT_ADDR, count[15:0]);
    param_mem_inst.preload(cnn_pkg::PARAM_WEIGHT_ADDR, {{8{weight_v[7]}}, weight_v});
    param_mem_inst.preload(cnn_pkg::PARAM_BIAS_ADDR, bias_v);
    param_mem_inst.preload(cnn_pkg::PARAM_SHIFT_ADDR, {13'd0, shift_v});
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic run_layer(input cnn_pkg::layer_mode_e mode, input int count,
                           input bit sat, input int inject_at);
    int cyc;
    bit saw_busy;
    if (busy_o) begin
      other_errors++;
      $display("DUT still busy before a new %s run", mode.name());
    end
    load_memories(mode, count, sat);
    run_mode   = mode;
    run_writes = (mode == cnn_pkg::MODE_CONV_1X1) ? count : count / 2;
    wr_count   = 0;
    done_seen  = 1'b0;
    run_active = 1'b1;
    saw_busy   = 1'b0;
    start_i    = 1'b1;
    mode_i     = mode;
    @(negedge clk);
    start_i = 1'b0;
    mode_i  = cnn_pkg::MODE_IDLE;
    cyc     = 1;
    while (!done_seen) begin
      if (busy_o) saw_busy = 1'b1;
      // Second start while busy, to be ignored
      if (cyc == inject_at) begin
        start_i = 1'b1;
        mode_i  = (mode == cnn_pkg::MODE_CONV_1X1) ? cnn_pkg::MODE_MAX_POOL :
                                                     cnn_pkg::MODE_CONV_1X1;
      end
      @(negedge clk);
      start_i = 1'b0;
      mode_i  = cnn_pkg::MODE_IDLE;
      cyc++;
    end
    if (!saw_busy) begin
      other_errors++;
      $display("busy_o never rose during the %s run", mode.name());
    end
    check_mode(mode, run_writes, wr_count);
    repeat (3) @(negedge clk);
  endtask

  task automatic ignored_start(input cnn_pkg::layer_mode_e mode);
    start_i = 1'b1;
    mode_i  = mode;
    @(negedge clk);
    start_i = 1'b0;
    mode_i  = cnn_pkg::MODE_IDLE;
    repeat (20) begin
      idle_bus_check("after an ignored start");
      @(negedge clk);
    end
  endtask

  initial begin
    seed         = 99;
    rst_n_i      = 1'b0;
    start_i      = 1'b0;
    mode_i       = cnn_pkg::MODE_IDLE;
    run_mode     = cnn_pkg::MODE_IDLE;
    run_writes   = 0;
    wr_count     = 0;
    run_active   = 1'b0;
    done_seen    = 1'b0;
    write_errors = 0;
    other_errors = 0;
    // Pool runs sit at 3, 4 and 6
    for (int k = 0; k < RUNS; k++) begin
      if (k == 3 || k == 4 || k == 6) counts[k] = 2 * (1 + {$random(seed)} % 32);
      else counts[k] = 2 + {$random(seed)} % 63;
    end
    counts[1] = 32;
    counts[4] = cnn_pkg::MAX_PIXELS;
    // Reset and both ignored starts count as empty tests
    cycle_limit = 3 * 30;
    for (int k = 0; k < RUNS; k++) begin
      cycle_limit += counts[k] * 4 + 30;
    end

    repeat (8) begin
      @(negedge clk);
      idle_bus_check("during reset");
    end
    rst_n_i = 1'b1;
    @(negedge clk);
    idle_bus_check("after reset");

    run_layer(cnn_pkg::MODE_CONV_1X1, counts[0], 1'b0, 0);
    run_layer(cnn_pkg::MODE_CONV_1X1, counts[1], 1'b1, 0);
    run_layer(cnn_pkg::MODE_CONV_1X1, counts[2], 1'b0, 0);
    run_layer(cnn_pkg::MODE_MAX_POOL, counts[3], 1'b0, 0);
    run_layer(cnn_pkg::MODE_MAX_POOL, counts[4], 1'b0, 0);
    // Back to back mode switching
    run_layer(cnn_pkg::MODE_CONV_1X1, counts[5], 1'b0, 0);
    run_layer(cnn_pkg::MODE_MAX_POOL, counts[6], 1'b0, 0);
    run_layer(cnn_pkg::MODE_CONV_1X1, counts[7], 1'b0, 0);
    ignored_start(cnn_pkg::MODE_IDLE);
    ignored_start(cnn_pkg::layer_mode_e'(4'd9));
    run_layer(cnn_pkg::MODE_CONV_1X1, counts[8], 1'b0, 6);

    repeat (5) @(negedge clk);
    $display("Errors: %0d value mismatches, %0d other failures", write_errors, other_errors);
    if (write_errors == 0 && other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: cnn_layer_engine.f
hw/cnn_pkg.sv
hw/conv_1x1_unit.sv
hw/maxpool_unit.sv
hw/bus_switcher.sv
hw/cnn_layer_top.sv
verif/sram_model.sv
verif/tb_cnn_layer.sv
